// ==== cpu16.f ====
+incdir+sim
verilog/cpu16_pkg.sv
verilog/program_loader.sv
verilog/main_memory.sv
verilog/alu.sv
verilog/control_unit.sv
verilog/store_port.sv
verilog/cpu16_top.sv
sim/tb_cpu16.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the cpu16 testbench with verilator and runs it
# exit status is nonzero when the build or the simulation fails

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_cpu16 \
    -f cpu16.f \
    -Mdir obj_dir \
    -o sim_cpu16
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_cpu16
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== sim/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// program table, one row per run
// code loads from address 0, data words from DATA_BASE up
localparam int          NUM_ROWS  = 23;
localparam logic [10:0] OUT_ADDR  = 11'd2047;
localparam logic [10:0] DATA_BASE = 11'd64;
localparam logic [10:0] SCRATCH   = 11'd100;

typedef struct packed {
    logic [15:0][15:0] code;
    int                n_code;
    logic [3:0][15:0]  data;
    // expected output words in order
    logic [7:0][15:0]  outs;
    int                n_out;
    // accumulator once halted
    logic [15:0]       acc;
    // instructions executed, halt included
    int                n_exec;
} prog_row_t;

prog_row_t rows [NUM_ROWS];

// opcode in the top five bits, address below
function automatic logic [15:0] instr(input logic [4:0] op, input logic [10:0] addr);
    return {op, addr};
endfunction

// expected alu result, k is the function number from the isa
function automatic logic [15:0] alu_expect(input int k, input logic [15:0] a,
                                           input logic [15:0] b);
    logic [31:0] wide;
    wide = 32'(a) * 32'(b);
    case (k)
        0:  return a + b;
        1:  return a - b;
        // low half of the product only
        2:  return wide[15:0];
        3:  return (b == 16'd0) ? 16'hffff : a / b;
        // shifts and rotates by one, b unused
        4:  return {a[14:0], 1'b0};
        5:  return {1'b0, a[15:1]};
        6:  return {a[14:0], a[15]};
        7:  return {a[0], a[15:1]};
        8:  return a & b;
        9:  return a | b;
        10: return a ^ b;
        11: return ~(a | b);
        12: return ~(a & b);
        13: return ~(a ^ b);
        14: return (a > b) ? 16'd1 : 16'd0;
        default: return (a == b) ? 16'd1 : 16'd0;
    endcase
endfunction

// load a, combine with b through function k, emit, halt
task automatic alu_row(input int n, input int k, input logic [15:0] a, input logic [15:0] b);
    rows[n] = '0;
    rows[n].code[0] = instr(cpu16_pkg::OP_LDA, DATA_BASE);
    rows[n].code[1] = instr(5'(16 + k), DATA_BASE + 11'd1);
    rows[n].code[2] = instr(cpu16_pkg::OP_STA, OUT_ADDR);
    rows[n].code[3] = instr(cpu16_pkg::OP_HLT, 11'd0);
    rows[n].data[0] = a;
    rows[n].data[1] = b;
    rows[n].outs[0] = alu_expect(k, a, b);
    rows[n].acc     = alu_expect(k, a, b);
    rows[n].n_code  = 4;
    rows[n].n_out   = 1;
    rows[n].n_exec  = 4;
endtask

task automatic build_table();
    logic [15:0] a;
    logic [15:0] b;
    // all sixteen functions on random operands
    for (int k = 0; k < 16; k++) begin
        random_word(a);
        random_word(b);
        alu_row(k, k, a, b);
    end
    random_word(a);
    // divide by zero, equal compare, greater compare both ways
    alu_row(16, 3, a, 16'd0);
    alu_row(17, 15, a, a);
    alu_row(18, 14, a, a);
    alu_row(19, 14, a | 16'd1, a >> 1);
    // ordinary store, overwrite acc, reload and emit
    rows[20] = '0;
    rows[20].code[0] = instr(cpu16_pkg::OP_LDA, DATA_BASE);
    rows[20].code[1] = instr(cpu16_pkg::OP_STA, SCRATCH);
    rows[20].code[2] = instr(cpu16_pkg::OP_LDA, DATA_BASE + 11'd1);
    rows[20].code[3] = instr(cpu16_pkg::OP_LDA, SCRATCH);
    rows[20].code[4] = instr(cpu16_pkg::OP_STA, OUT_ADDR);
    rows[20].code[5] = instr(cpu16_pkg::OP_HLT, 11'd0);
    rows[20].data[0] = a;
    rows[20].data[1] = ~a;
    rows[20].outs[0] = a;
    rows[20].acc     = a;
    rows[20].n_code  = 6;
    rows[20].n_out   = 1;
    rows[20].n_exec  = 6;
    // jump skips a second load and output
    rows[21] = '0;
    rows[21].code[0] = instr(cpu16_pkg::OP_LDA, DATA_BASE);
    rows[21].code[1] = instr(cpu16_pkg::OP_STA, OUT_ADDR);
    rows[21].code[2] = instr(cpu16_pkg::OP_JMP, 11'd5);
    rows[21].code[3] = instr(cpu16_pkg::OP_LDA, DATA_BASE + 11'd1);
    rows[21].code[4] = instr(cpu16_pkg::OP_STA, OUT_ADDR);
    rows[21].code[5] = instr(cpu16_pkg::OP_HLT, 11'd0);
    rows[21].data[0] = 16'h00a5;
    rows[21].data[1] = 16'h0f0f;
    rows[21].outs[0] = 16'h00a5;
    rows[21].acc     = 16'h00a5;
    rows[21].n_code  = 6;
    rows[21].n_out   = 1;
    rows[21].n_exec  = 4;
    // countdown from 3, jz leaves the loop once acc hits zero
    rows[22] = '0;
    rows[22].code[0] = instr(cpu16_pkg::OP_LDA, DATA_BASE);
    rows[22].code[1] = instr(cpu16_pkg::OP_STA, OUT_ADDR);
    rows[22].code[2] = instr(cpu16_pkg::OP_JZ, 11'd6);
    rows[22].code[3] = instr(cpu16_pkg::OP_SUB, DATA_BASE + 11'd1);
    rows[22].code[4] = instr(cpu16_pkg::OP_JMP, 11'd1);
    rows[22].code[5] = instr(cpu16_pkg::OP_HLT, 11'd0);
    rows[22].code[6] = instr(cpu16_pkg::OP_HLT, 11'd0);
    rows[22].data[0] = 16'd3;
    rows[22].data[1] = 16'd1;
    rows[22].outs[0] = 16'd3;
    rows[22].outs[1] = 16'd2;
    rows[22].outs[2] = 16'd1;
    rows[22].outs[3] = 16'd0;
    rows[22].acc     = 16'd0;
    rows[22].n_code  = 7;
    rows[22].n_out   = 4;
    rows[22].n_exec  = 16;
endtask

`endif

// ==== sim/tb_cpu16.sv ====
`timescale 1ns/1ps

module tb_cpu16;

    logic        clock;
    logic        arst_n;
    logic        load_we;
    logic [10:0] load_addr;
    logic [15:0] load_data;
    logic        start;
    logic        halted;
    logic        out_valid;
    logic [15:0] out_data;
    logic [15:0] acc_value;

    logic [31:0] lfsr_state;
    logic [15:0] got_words [$];
    int          cur_row;
    int          cycle_count = 0;
    int          cycle_limit;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic random_word(output logic [15:0] w);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    `include "tb_programs.svh"

    cpu16_top #(
        .OUT_ADDR (OUT_ADDR)
    ) dut0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .halted    (halted),
        .out_valid (out_valid),
        .out_data  (out_data),
        .acc_value (acc_value)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        stop_run($sformatf("ERR t=%0t row %0d %s got %h expected %h",
                           $time, cur_row, name, got, exp));
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // code from address 0, then the four data words
    task automatic load_row(input int r);
        for (int i = 0; i < rows[r].n_code; i++) begin
            next_cycle();
            load_we   = 1'b1;
            load_addr = 11'(i);
            load_data = rows[r].code[i];
        end
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            load_we   = 1'b1;
            load_addr = DATA_BASE + 11'(i);
            load_data = rows[r].data[i];
        end
        next_cycle();
        load_we = 1'b0;
    endtask

    // start pulse, then wait for halted to come back
    task automatic run_row();
        got_words.delete();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        @(negedge clock);
        assert (halted === 1'b0) else stop_run("machine stayed stopped after start");
        while (halted !== 1'b1) begin
            @(negedge clock);
        end
    endtask

    task automatic check_row(input int r);
        assert (got_words.size() == rows[r].n_out)
            else value_error("out_valid count", 16'(got_words.size()), 16'(rows[r].n_out));
        for (int i = 0; i < got_words.size(); i++) begin
            assert (got_words[i] === rows[r].outs[i])
                else value_error("out_data", got_words[i], rows[r].outs[i]);
        end
        assert (acc_value === rows[r].acc)
            else value_error("acc_value", acc_value, rows[r].acc);
    endtask

    // collect output words mid-cycle, none allowed while stopped
    always @(negedge clock) begin
        if (arst_n) begin
            assert (!(out_valid && halted))
                else stop_run("output strobe seen while the machine was stopped");
            if (out_valid) begin
                got_words.push_back(out_data);
            end
        end
    end

    // watchdog
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        arst_n     = 1'b0;
        load_we    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        cur_row    = -1;
        lfsr_state = 32'h4256;
        build_table();
        // loading, start, four cycles per instruction, plus slack
        cycle_limit = 64;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += rows[r].n_code + 4 + 4 * rows[r].n_exec + 8;
        end
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
        // reset state
        @(negedge clock);
        assert (halted === 1'b1) else value_error("halted", 16'(halted), 16'd1);
        assert (out_valid === 1'b0) else value_error("out_valid", 16'(out_valid), 16'd0);
        assert (acc_value === 16'd0) else value_error("acc_value", acc_value, 16'd0);
        // idle a while, monitor catches any stray strobe
        repeat (4) @(negedge clock);
        // every row reloads memory and restarts from address 0
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_row = r;
            load_row(r);
            run_row();
            check_row(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== verilog/cpu16_top.sv ====
`timescale 1ns/1ps

module cpu16_top #(
    parameter logic [cpu16_pkg::ADDR_WIDTH-1:0] OUT_ADDR = 11'd2047
) (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                load_we,
    input  logic [cpu16_pkg::ADDR_WIDTH-1:0]    load_addr,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    load_data,
    input  logic                                start,
    output logic                                halted,
    output logic                                out_valid,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    out_data,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    acc_value
);

    cpu16_pkg::mem_req_t                rd_req;
    cpu16_pkg::mem_req_t                wr_req;
    cpu16_pkg::mem_req_t                cpu_req;
    cpu16_pkg::mem_req_t                mem_req;
    cpu16_pkg::store_t                  store;
    cpu16_pkg::alu_op_t                 alu_op;
    logic                               running;
    logic                               halt;
    logic [cpu16_pkg::DATA_WIDTH-1:0]   rdata;
    logic [cpu16_pkg::DATA_WIDTH-1:0]   alu_a;
    logic [cpu16_pkg::DATA_WIDTH-1:0]   alu_b;
    logic [cpu16_pkg::DATA_WIDTH-1:0]   alu_result;

    // reads and writes never overlap, both are zero when idle
    assign cpu_req = rd_req | wr_req;

    program_loader u_loader (
        .clock     (clock),
        .arst_n    (arst_n),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .halt      (halt),
        .cpu_req   (cpu_req),
        .mem_req   (mem_req),
        .running   (running),
        .halted    (halted)
    );

    main_memory u_memory (
        .clock   (clock),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    control_unit u_control (
        .clock      (clock),
        .arst_n     (arst_n),
        .running    (running),
        .rdata      (rdata),
        .alu_result (alu_result),
        .rd_req     (rd_req),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .store      (store),
        .halt       (halt),
        .acc_value  (acc_value)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    store_port #(
        .OUT_ADDR (OUT_ADDR)
    ) u_store (
        .clock     (clock),
        .arst_n    (arst_n),
        .store     (store),
        .wr_req    (wr_req),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verilog/store_port.sv ====
`timescale 1ns/1ps

module store_port #(
    parameter logic [cpu16_pkg::ADDR_WIDTH-1:0] OUT_ADDR = 11'd2047
) (
    input  logic                                clock,
    input  logic                                arst_n,
    input  cpu16_pkg::store_t                   store,
    output cpu16_pkg::mem_req_t                 wr_req,
    output logic                                out_valid,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    out_data
);

    logic to_output;

    // reserved address goes to the port, never to memory
    assign to_output = store.valid && (store.addr == OUT_ADDR);

    // ordinary stores become memory writes
    // all zero when idle so the top can or it with reads
    always_comb begin
        wr_req = '0;
        if (store.valid && !to_output) begin
            wr_req.addr  = store.addr;
            wr_req.wdata = store.data;
            wr_req.we    = 1'b1;
        end
    end

    // one-cycle output strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= to_output;
        end
    end

    // data only meaningful with the strobe
    always_ff @(posedge clock) begin
        if (to_output) begin
            out_data <= store.data;
        end
    end

    // stores are at least four cycles apart
    a_single_strobe: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid |=> !out_valid);

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                running,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    rdata,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    alu_result,
    output cpu16_pkg::mem_req_t                 rd_req,
    output cpu16_pkg::alu_op_t                  alu_op,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    alu_a,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    alu_b,
    output cpu16_pkg::store_t                   store,
    output logic                                halt,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    acc_value
);

    // four cycles per instruction once out of idle
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        LOAD_IR,
        OPERAND,
        EXECUTE
    } state_t;

    state_t                             state;
    logic [cpu16_pkg::ADDR_WIDTH-1:0]   pc;
    cpu16_pkg::instr_t                  ir;
    logic [cpu16_pkg::DATA_WIDTH-1:0]   acc;
    logic                               is_alu_op;
    logic                               jump_taken;

    // opcodes with the top bit set go through the alu
    assign is_alu_op = ir.op[4];

    // conditional jump looks at acc before this instruction
    assign jump_taken = (ir.op == cpu16_pkg::OP_JMP) ||
                        ((ir.op == cpu16_pkg::OP_JZ) && (acc == '0));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // every run starts at address 0
                    if (running) begin
                        state <= FETCH;
                        pc    <= '0;
                    end
                end
                FETCH: begin
                    state <= LOAD_IR;
                end
                LOAD_IR: begin
                    state <= OPERAND;
                    // wraps from the top address back to 0
                    pc    <= pc + 1'b1;
                end
                OPERAND: begin
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if (ir.op == cpu16_pkg::OP_HLT) begin
                        state <= IDLE;
                    end else begin
                        state <= FETCH;
                    end
                    if (jump_taken) begin
                        pc <= ir.addr;
                    end
                    // rdata holds the operand word in execute
                    if (is_alu_op) begin
                        acc <= alu_result;
                    end else if (ir.op == cpu16_pkg::OP_LDA) begin
                        acc <= rdata;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // instruction word arrives one cycle after fetch
    always_ff @(posedge clock) begin
        if (state == LOAD_IR) begin
            ir <= cpu16_pkg::instr_t'(rdata);
        end
    end

    // read requests
    // instruction in fetch, operand in operand state, idle otherwise
    always_comb begin
        rd_req = '0;
        if (state == FETCH) begin
            rd_req.addr = pc;
        end else if (state == OPERAND) begin
            rd_req.addr = ir.addr;
        end
    end

    // alu sees acc and the operand word
    assign alu_op = cpu16_pkg::alu_op_t'(ir.op[3:0]);
    assign alu_a  = acc;
    assign alu_b  = rdata;

    // store leaves in execute and the store port routes it
    assign store.valid = (state == EXECUTE) && (ir.op == cpu16_pkg::OP_STA);
    assign store.addr  = ir.addr;
    assign store.data  = acc;

    assign halt      = (state == EXECUTE) && (ir.op == cpu16_pkg::OP_HLT);
    assign acc_value = acc;

    // stores only while the loader hands the memory port to the cpu
    a_store_while_running: assert property (@(posedge clock) disable iff (!arst_n)
        store.valid |-> running);

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu16_pkg::alu_op_t                  op,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    a,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    b,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    result
);

    localparam int W = cpu16_pkg::DATA_WIDTH;

    always_comb begin
        case (op)
            // arithmetic, all truncated to the word width
            cpu16_pkg::ALU_ADD: result = a + b;
            cpu16_pkg::ALU_SUB: result = a - b;
            // low half of the product
            cpu16_pkg::ALU_MUL: result = a * b;
            cpu16_pkg::ALU_DIV: begin
                // divide by zero saturates to all ones
                if (b == '0) begin
                    result = '1;
                end else begin
                    result = a / b;
                end
            end
            // single-bit shifts and rotates, b ignored
            cpu16_pkg::ALU_SHL: result = a << 1;
            cpu16_pkg::ALU_SHR: result = a >> 1;
            cpu16_pkg::ALU_ROL: result = {a[W-2:0], a[W-1]};
            cpu16_pkg::ALU_ROR: result = {a[0], a[W-1:1]};
            // bitwise logic
            cpu16_pkg::ALU_AND:  result = a & b;
            cpu16_pkg::ALU_OR:   result = a | b;
            cpu16_pkg::ALU_XOR:  result = a ^ b;
            cpu16_pkg::ALU_NOR:  result = ~(a | b);
            cpu16_pkg::ALU_NAND: result = ~(a & b);
            cpu16_pkg::ALU_XNOR: result = ~(a ^ b);
            // compares give 1 or 0, unsigned
            cpu16_pkg::ALU_GT: result = {{(W-1){1'b0}}, a > b};
            cpu16_pkg::ALU_EQ: result = {{(W-1){1'b0}}, a == b};
            default: result = '0;
        endcase
    end

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
    input  logic                                clock,
    input  cpu16_pkg::mem_req_t                 mem_req,
    output logic [cpu16_pkg::DATA_WIDTH-1:0]    rdata
);

    // depth set by the instruction address field
    localparam int DEPTH = 1 << cpu16_pkg::ADDR_WIDTH;

    // program and data share this array
    logic [cpu16_pkg::DATA_WIDTH-1:0] mem [0:DEPTH-1];

    // single port
    // a write cycle leaves rdata holding the last read
    always_ff @(posedge clock) begin
        if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end else begin
            // registered read, data one cycle after the request
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

// ==== verilog/program_loader.sv ====
`timescale 1ns/1ps

module program_loader (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                load_we,
    input  logic [cpu16_pkg::ADDR_WIDTH-1:0]    load_addr,
    input  logic [cpu16_pkg::DATA_WIDTH-1:0]    load_data,
    input  logic                                start,
    input  logic                                halt,
    input  cpu16_pkg::mem_req_t                 cpu_req,
    output cpu16_pkg::mem_req_t                 mem_req,
    output logic                                running,
    output logic                                halted
);

    // stopped while loading, running between start and halt
    typedef enum logic {
        LOADING,
        RUNNING
    } load_state_t;

    load_state_t state;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= LOADING;
        end else begin
            case (state)
                LOADING: begin
                    if (start) begin
                        state <= RUNNING;
                    end
                end
                RUNNING: begin
                    // halt comes from execute of the halt instruction
                    if (halt) begin
                        state <= LOADING;
                    end
                end
                default: state <= LOADING;
            endcase
        end
    end

    assign running = (state == RUNNING);
    assign halted  = (state == LOADING);

    // memory port owner
    // external loader while stopped, cpu while running
    always_comb begin
        if (running) begin
            mem_req = cpu_req;
        end else begin
            mem_req.addr  = load_addr;
            mem_req.wdata = load_data;
            mem_req.we    = load_we;
        end
    end

    // loader must stay off the port once the program runs
    a_no_load_while_running: assert property (@(posedge clock) disable iff (!arst_n)
        running |-> !load_we);

    // a second start would restart a program mid-flight
    a_no_start_while_running: assert property (@(posedge clock) disable iff (!arst_n)
        running |-> !start);

endmodule

// ==== verilog/cpu16_pkg.sv ====
package cpu16_pkg;

    // machine word and memory address widths
    parameter int DATA_WIDTH = 16;
    parameter int ADDR_WIDTH = 11;

    // alu function select, same order as the opcode low bits
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_DIV,
        ALU_SHL,
        ALU_SHR,
        ALU_ROL,
        ALU_ROR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_NAND,
        ALU_XNOR,
        ALU_GT,
        ALU_EQ
    } alu_op_t;

    // instruction opcode
    // top bit set means alu op, low four bits pick the function
    typedef enum logic [4:0] {
        OP_LDA  = 5'd0,
        OP_STA  = 5'd1,
        OP_JMP  = 5'd2,
        OP_JZ   = 5'd3,
        OP_HLT  = 5'd4,
        OP_ADD  = 5'd16,
        OP_SUB  = 5'd17,
        OP_MUL  = 5'd18,
        OP_DIV  = 5'd19,
        OP_SHL  = 5'd20,
        OP_SHR  = 5'd21,
        OP_ROL  = 5'd22,
        OP_ROR  = 5'd23,
        OP_AND  = 5'd24,
        OP_OR   = 5'd25,
        OP_XOR  = 5'd26,
        OP_NOR  = 5'd27,
        OP_NAND = 5'd28,
        OP_XNOR = 5'd29,
        OP_GT   = 5'd30,
        OP_EQ   = 5'd31
    } cpu_op_t;

    // one instruction word
    typedef struct packed {
        cpu_op_t                op;
        logic [ADDR_WIDTH-1:0]  addr;
    } instr_t;

    // one access on the memory port
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  wdata;
        logic                   we;
    } mem_req_t;

    // store leaving the control unit
    typedef struct packed {
        logic                   valid;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
    } store_t;

endpackage
